// ==== rtl/fxp_bus_pkg.sv ====
`default_nettype none

// Bus-side types and the register map of the accelerator
package fxp_bus_pkg;

	// ------------------------------------------------------------
	// Bus request as seen on the pins
	// ------------------------------------------------------------
	typedef struct packed {
		logic       vda;     // Valid data address
		logic       rw;      // High for read
		logic [7:0] offset;  // Low address byte
		logic [7:0] wdata;
	} bus_req_t;

	// Decoded register access toward the register block
	typedef struct packed {
		logic       wr;      // One cycle per bus write
		logic       rd;      // Capture strobe for read data
		logic [7:0] offset;
		logic [7:0] wdata;
	} reg_access_t;

	// Status byte layout as read back from CMD_OFFSET
	typedef struct packed {
		logic       busy;
		logic [1:0] spare;   // Always zero
		logic       lt;
		logic       eq;
		logic       gt;
		logic       zf;
		logic       vf;
	} status_t;

	// ------------------------------------------------------------
	// Register offsets inside the 256 byte window
	// ------------------------------------------------------------
	localparam logic [7:0] FAC1_BASE  = 8'h00;
	// Command on write and status on read
	localparam logic [7:0] CMD_OFFSET = 8'h0E;
	localparam logic [7:0] FAC2_BASE  = 8'h10;

endpackage

`default_nettype wire

// ==== rtl/fxp_op_pkg.sv ====
`default_nettype none

// Operation side types shared by the sequencer, ALU and registers
package fxp_op_pkg;

	// Command byte encodings
	typedef enum logic [7:0] {
		OP_ADD  = 8'h81,
		OP_SUB  = 8'h82,
		OP_MUL  = 8'h83,
		OP_ABS  = 8'h87,
		OP_NABS = 8'h88,
		OP_NEG  = 8'h90,
		OP_SWAP = 8'h11
	} fxp_opcode_e;

	// Sequencer states
	typedef enum logic [3:0] {
		ST_IDLE,
		ST_EXEC,
		ST_MUL_ABS1,
		ST_MUL_SWAP,
		ST_MUL_ABS2,
		ST_MUL_STEP,
		ST_MUL_SIGN
	} seq_state_e;

	// Source of the next FAC1 value
	typedef enum logic [2:0] {
		UPD_NONE,
		UPD_SUM,
		UPD_NEG,
		UPD_SWAP,
		UPD_SHIFT,
		UPD_CLEAR
	} fac_update_e;

	// Per cycle accumulator control from the sequencer
	typedef struct packed {
		fac_update_e upd;
		logic        sub_sel;   // ALU computes FAC2 - FAC1
		logic        shift_in;  // Bit entering FAC1 msb on a shift
	} fac_ctrl_t;

	// ALU flags
	typedef struct packed {
		logic cf;  // Carry out of the adder
		logic vf;  // Signed overflow of the add or subtract
		logic nf;  // Sign of the negated FAC1
		logic lt;
		logic eq;
		logic gt;
		logic zf;  // FAC1 is zero
	} alu_flags_t;

endpackage

`default_nettype wire

// ==== rtl/fxp_bus_port.sv ====
`default_nettype none
`timescale 1ns/1ps

module fxp_bus_port #(
	parameter logic [23:0] BASE_ADDR = 24'hFEA200
) (
	input  wire logic                     clk,
	input  wire logic                     rst,
	input  wire fxp_bus_pkg::bus_req_t    req,
	input  wire logic [15:0]              ad_high,
	output fxp_bus_pkg::reg_access_t      access,
	output logic                          rdy
);

	logic       cs;
	logic       rd_req;
	logic [1:0] wait_cnt;

	// Chip select on the upper 16 address bits
	assign cs     = req.vda && (ad_high == BASE_ADDR[23:8]);
	assign rd_req = cs && req.rw;

	// ------------------------------------------------------------
	// Read wait states
	// ------------------------------------------------------------
	// Counts 0 and 1 hold rdy low
	// Count 2 is the data cycle and wraps back to 0
	always_ff @(posedge clk) begin
		if (rst) begin
			wait_cnt <= 2'd0;
		end else if (rd_req && wait_cnt != 2'd2) begin
			wait_cnt <= wait_cnt + 2'd1;
		end else begin
			wait_cnt <= 2'd0;
		end
	end

	// Writes never stall
	assign rdy = !(rd_req && wait_cnt != 2'd2);

	// Read strobe one cycle ahead of rdy
	// so the registered byte sits on rdata while rdy is high
	assign access = '{
		wr:     cs && !req.rw,
		rd:     rd_req && (wait_cnt == 2'd1),
		offset: req.offset,
		wdata:  req.wdata
	};

endmodule

`default_nettype wire

// ==== rtl/fxp_regs.sv ====
`default_nettype none
`timescale 1ns/1ps

module fxp_regs #(
	parameter int FAC_BYTES = 10
) (
	input  wire logic                         clk,
	input  wire logic                         rst,
	input  wire fxp_bus_pkg::reg_access_t     access,
	input  wire fxp_op_pkg::fac_ctrl_t        ctrl,
	input  wire logic                         busy,
	input  wire logic                         vf,
	input  wire logic [8*FAC_BYTES-1:0]       sum,
	input  wire logic [8*FAC_BYTES-1:0]       neg,
	input  wire fxp_op_pkg::alu_flags_t       flags,
	output logic [8*FAC_BYTES-1:0]            fac1,
	output logic [8*FAC_BYTES-1:0]            fac2,
	output logic [7:0]                        cmd,
	output logic                              cmd_valid,
	output logic [7:0]                        rdata
);

	localparam int W = 8 * FAC_BYTES;

	fxp_bus_pkg::status_t status;
	logic [7:0]           rd_byte;

	// Command handoff straight from the bus write
	// A command while busy is dropped here
	assign cmd_valid = access.wr && !busy && (access.offset == fxp_bus_pkg::CMD_OFFSET);
	assign cmd       = access.wdata;

	// ------------------------------------------------------------
	// Accumulators
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			fac1 <= '0;
			fac2 <= '0;
		end else begin
			// Sequencer updates only arrive while busy
			case (ctrl.upd)
				fxp_op_pkg::UPD_SUM:   fac1 <= sum;
				fxp_op_pkg::UPD_NEG:   fac1 <= neg;
				fxp_op_pkg::UPD_SWAP: begin
					fac1 <= fac2;
					fac2 <= fac1;
				end
				fxp_op_pkg::UPD_SHIFT: fac1 <= {ctrl.shift_in, fac1[W-1:1]};
				fxp_op_pkg::UPD_CLEAR: fac1 <= '0;
				default: ;
			endcase
			// Byte writes from the bus when idle
			if (access.wr && !busy) begin
				for (int i = 0; i < FAC_BYTES; i++) begin
					if (access.offset == fxp_bus_pkg::FAC1_BASE + 8'(i))
						fac1[8*i +: 8] <= access.wdata;
					if (access.offset == fxp_bus_pkg::FAC2_BASE + 8'(i))
						fac2[8*i +: 8] <= access.wdata;
				end
			end
		end
	end

	// ------------------------------------------------------------
	// Status and read path
	// ------------------------------------------------------------
	assign status = '{
		busy:  busy,
		spare: 2'b00,
		lt:    flags.lt,
		eq:    flags.eq,
		gt:    flags.gt,
		zf:    flags.zf,
		vf:    vf
	};

	// Unmapped offsets read as zero
	always_comb begin
		rd_byte = 8'h00;
		if (access.offset == fxp_bus_pkg::CMD_OFFSET)
			rd_byte = status;
		for (int i = 0; i < FAC_BYTES; i++) begin
			if (access.offset == fxp_bus_pkg::FAC1_BASE + 8'(i))
				rd_byte = fac1[8*i +: 8];
			if (access.offset == fxp_bus_pkg::FAC2_BASE + 8'(i))
				rd_byte = fac2[8*i +: 8];
		end
	end

	// Captured on the read strobe and held until the next read
	always_ff @(posedge clk) begin
		if (access.rd)
			rdata <= rd_byte;
	end

endmodule

`default_nettype wire

// ==== rtl/fxp_alu.sv ====
`default_nettype none
`timescale 1ns/1ps

module fxp_alu #(
	parameter int FAC_BYTES = 10
) (
	input  wire logic [8*FAC_BYTES-1:0]   fac1,
	input  wire logic [8*FAC_BYTES-1:0]   fac2,
	input  wire logic                     sub_sel,
	output logic [8*FAC_BYTES-1:0]        sum,
	output logic [8*FAC_BYTES-1:0]        neg,
	output fxp_op_pkg::alu_flags_t        flags
);

	localparam int W = 8 * FAC_BYTES;

	logic [W:0] sum_ext;

	// ------------------------------------------------------------
	// Adder with one extra bit for the carry
	// ------------------------------------------------------------
	// FAC2 is always the left operand
	assign sum_ext = sub_sel ? ({1'b0, fac2} - {1'b0, fac1})
	                         : ({1'b0, fac2} + {1'b0, fac1});
	assign sum     = sum_ext[W-1:0];

	// Two's complement of FAC1
	assign neg = {W{1'b0}} - fac1;

	always_comb begin
		flags.cf = sum_ext[W];
		// Overflow when the effective operand signs agree
		// and the result sign differs from FAC2
		flags.vf = !(fac2[W-1] ^ fac1[W-1] ^ sub_sel) && (sum[W-1] ^ fac2[W-1]);
		// Negation overflows only when this and the FAC1 sign are both set
		flags.nf = neg[W-1];
		// Signed compare of FAC1 against FAC2
		flags.gt = $signed(fac1) > $signed(fac2);
		flags.eq = fac1 == fac2;
		flags.lt = !(flags.gt || flags.eq);
		flags.zf = ~|fac1;
	end

endmodule

`default_nettype wire

// ==== rtl/fxp_sequencer.sv ====
`default_nettype none
`timescale 1ns/1ps

module fxp_sequencer #(
	parameter int FAC_BYTES = 10
) (
	input  wire logic                     clk,
	input  wire logic                     rst,
	input  wire logic [7:0]               cmd,
	input  wire logic                     cmd_valid,
	input  wire logic                     fac1_lsb,
	input  wire logic                     fac1_msb,
	input  wire logic                     fac2_msb,
	input  wire fxp_op_pkg::alu_flags_t   flags,
	output fxp_op_pkg::fac_ctrl_t         ctrl,
	output logic                          busy,
	output logic                          vf
);

	localparam int                W        = 8 * FAC_BYTES;
	localparam int                CNT_W    = $clog2(W);
	localparam logic [CNT_W-1:0]  LAST_BIT = CNT_W'(W - 1);

	fxp_op_pkg::seq_state_e  state;
	fxp_op_pkg::fxp_opcode_e op;
	logic                    sign;      // Product sign
	logic                    loading;   // Multiplier still moving in from FAC1
	logic                    shift_ph;  // Second half of a multiply step
	logic                    carry;     // Adder carry kept for the shift
	logic [CNT_W-1:0]        bit_cnt;
	logic [W-1:0]            mq;        // Multiplier shift register
	logic                    last_bit;
	logic                    neg_ovf;

	assign busy     = state != fxp_op_pkg::ST_IDLE;
	assign last_bit = bit_cnt == LAST_BIT;
	// Only the most negative value keeps its sign when negated
	assign neg_ovf  = fac1_msb && flags.nf;

	// ------------------------------------------------------------
	// Accumulator control per state
	// ------------------------------------------------------------
	always_comb begin
		ctrl.upd      = fxp_op_pkg::UPD_NONE;
		ctrl.sub_sel  = 1'b0;
		ctrl.shift_in = 1'b0;
		case (state)
			fxp_op_pkg::ST_EXEC: begin
				case (op)
					fxp_op_pkg::OP_ADD:  ctrl.upd = fxp_op_pkg::UPD_SUM;
					fxp_op_pkg::OP_SUB: begin
						ctrl.upd     = fxp_op_pkg::UPD_SUM;
						ctrl.sub_sel = 1'b1;
					end
					fxp_op_pkg::OP_NEG:  ctrl.upd = fxp_op_pkg::UPD_NEG;
					fxp_op_pkg::OP_ABS:
						if (fac1_msb) ctrl.upd = fxp_op_pkg::UPD_NEG;
					fxp_op_pkg::OP_NABS:
						if (!fac1_msb) ctrl.upd = fxp_op_pkg::UPD_NEG;
					fxp_op_pkg::OP_SWAP: ctrl.upd = fxp_op_pkg::UPD_SWAP;
					default: ;
				endcase
			end
			// Both operands made positive around one swap
			fxp_op_pkg::ST_MUL_ABS1, fxp_op_pkg::ST_MUL_ABS2:
				if (fac1_msb) ctrl.upd = fxp_op_pkg::UPD_NEG;
			fxp_op_pkg::ST_MUL_SWAP: ctrl.upd = fxp_op_pkg::UPD_SWAP;
			fxp_op_pkg::ST_MUL_STEP: begin
				if (loading) begin
					// Rotate FAC1 through the multiplier then clear on the last bit
					ctrl.upd      = last_bit ? fxp_op_pkg::UPD_CLEAR : fxp_op_pkg::UPD_SHIFT;
					ctrl.shift_in = fac1_lsb;
				end else if (!shift_ph) begin
					// Add the multiplicand in FAC2 when the multiplier bit is set
					if (mq[0]) ctrl.upd = fxp_op_pkg::UPD_SUM;
				end else begin
					ctrl.upd      = fxp_op_pkg::UPD_SHIFT;
					ctrl.shift_in = carry;
				end
			end
			fxp_op_pkg::ST_MUL_SIGN:
				if (sign) ctrl.upd = fxp_op_pkg::UPD_NEG;
			default: ;
		endcase
	end

	// ------------------------------------------------------------
	// State, flags and multiply bookkeeping
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= fxp_op_pkg::ST_IDLE;
			vf       <= 1'b0;
			sign     <= 1'b0;
			loading  <= 1'b0;
			shift_ph <= 1'b0;
			bit_cnt  <= '0;
		end else begin
			case (state)
				fxp_op_pkg::ST_IDLE: begin
					op <= fxp_op_pkg::fxp_opcode_e'(cmd);
					if (cmd_valid) begin
						case (cmd)
							fxp_op_pkg::OP_ADD, fxp_op_pkg::OP_SUB, fxp_op_pkg::OP_NEG,
							fxp_op_pkg::OP_ABS, fxp_op_pkg::OP_NABS, fxp_op_pkg::OP_SWAP:
								state <= fxp_op_pkg::ST_EXEC;
							fxp_op_pkg::OP_MUL: begin
								vf    <= 1'b0;
								state <= fxp_op_pkg::ST_MUL_ABS1;
							end
							// Unknown commands are ignored
							default: ;
						endcase
					end
				end
				fxp_op_pkg::ST_EXEC: begin
					case (op)
						fxp_op_pkg::OP_ADD, fxp_op_pkg::OP_SUB:
							vf <= flags.vf;
						fxp_op_pkg::OP_NEG, fxp_op_pkg::OP_ABS, fxp_op_pkg::OP_NABS:
							vf <= (ctrl.upd == fxp_op_pkg::UPD_NEG) && neg_ovf;
						default: ;
					endcase
					state <= fxp_op_pkg::ST_IDLE;
				end
				fxp_op_pkg::ST_MUL_ABS1: begin
					// Result is negative when the operand signs differ
					sign  <= fac1_msb ^ fac2_msb;
					state <= fxp_op_pkg::ST_MUL_SWAP;
				end
				fxp_op_pkg::ST_MUL_SWAP: state <= fxp_op_pkg::ST_MUL_ABS2;
				fxp_op_pkg::ST_MUL_ABS2: begin
					loading <= 1'b1;
					bit_cnt <= '0;
					state   <= fxp_op_pkg::ST_MUL_STEP;
				end
				fxp_op_pkg::ST_MUL_STEP: begin
					if (loading) begin
						mq <= {fac1_lsb, mq[W-1:1]};
						if (last_bit) begin
							loading  <= 1'b0;
							shift_ph <= 1'b0;
							bit_cnt  <= '0;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end else if (!shift_ph) begin
						carry    <= mq[0] && flags.cf;
						shift_ph <= 1'b1;
					end else begin
						// Low product bits are dropped
						mq       <= {1'b0, mq[W-1:1]};
						shift_ph <= 1'b0;
						if (last_bit)
							state <= fxp_op_pkg::ST_MUL_SIGN;
						else
							bit_cnt <= bit_cnt + 1'b1;
					end
				end
				fxp_op_pkg::ST_MUL_SIGN: state <= fxp_op_pkg::ST_IDLE;
				default: state <= fxp_op_pkg::ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/fxp_accel.sv ====
`default_nettype none
`timescale 1ns/1ps

// Fixed point accelerator on a byte wide bus
// FAC_BYTES above 14 would run FAC1 into the command offset
module fxp_accel #(
	parameter int          FAC_BYTES = 10,
	parameter logic [23:0] BASE_ADDR = 24'hFEA200
) (
	input  wire logic        clk,
	input  wire logic        rst,
	input  wire logic        vda,
	input  wire logic        rw,
	input  wire logic [23:0] ad,
	input  wire logic [7:0]  wdata,
	output logic [7:0]       rdata,
	output logic             rdy
);

	localparam int W = 8 * FAC_BYTES;

	fxp_bus_pkg::bus_req_t    req;
	fxp_bus_pkg::reg_access_t access;
	fxp_op_pkg::fac_ctrl_t    ctrl;
	fxp_op_pkg::alu_flags_t   flags;
	logic [W-1:0]             fac1;
	logic [W-1:0]             fac2;
	logic [W-1:0]             sum;
	logic [W-1:0]             neg;
	logic [7:0]               cmd;
	logic                     cmd_valid;
	logic                     busy;
	logic                     vf;

	assign req = '{vda: vda, rw: rw, offset: ad[7:0], wdata: wdata};

	// ------------------------------------------------------------
	// Bus decode and register file
	// ------------------------------------------------------------
	fxp_bus_port #(.BASE_ADDR(BASE_ADDR)) u_bus_port (
		.clk(clk), .rst(rst), .req(req), .ad_high(ad[23:8]), .access(access), .rdy(rdy)
	);

	fxp_regs #(.FAC_BYTES(FAC_BYTES)) u_regs (
		.clk(clk), .rst(rst), .access(access), .ctrl(ctrl), .busy(busy), .vf(vf),
		.sum(sum), .neg(neg), .flags(flags), .fac1(fac1), .fac2(fac2),
		.cmd(cmd), .cmd_valid(cmd_valid), .rdata(rdata)
	);

	// ------------------------------------------------------------
	// Datapath and control
	// ------------------------------------------------------------
	fxp_alu #(.FAC_BYTES(FAC_BYTES)) u_alu (
		.fac1(fac1), .fac2(fac2), .sub_sel(ctrl.sub_sel), .sum(sum), .neg(neg), .flags(flags)
	);

	fxp_sequencer #(.FAC_BYTES(FAC_BYTES)) u_sequencer (
		.clk(clk), .rst(rst), .cmd(cmd), .cmd_valid(cmd_valid),
		.fac1_lsb(fac1[0]), .fac1_msb(fac1[W-1]), .fac2_msb(fac2[W-1]),
		.flags(flags), .ctrl(ctrl), .busy(busy), .vf(vf)
	);

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`default_nettype none
`timescale 1ns/1ps

// Free running clock and a reset held for the first few rising edges
module tb_clock #(
	parameter int HALF_PERIOD_NS = 50,
	parameter int RESET_CYCLES   = 2
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD_NS) clk = ~clk;
	end

	// Reset drops shortly after an edge like the rest of the stimulus
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;
	end

endmodule

`default_nettype wire

// ==== tests/fxp_accel_checker.sv ====
`default_nettype none
`timescale 1ns/1ps

// Bus protocol properties on the accelerator pins
module fxp_accel_checker #(
	parameter logic [23:0] BASE_ADDR = 24'hFEA200
) (
	input wire logic        clk,
	input wire logic        rst,
	input wire logic        vda,
	input wire logic        rw,
	input wire logic [23:0] ad,
	input wire logic [7:0]  rdata,
	input wire logic        rdy
);

	int unsigned fail_cnt = 0;
	logic        rd_sel;

	// Read aimed at this device
	assign rd_sel = vda && rw && (ad[23:8] == BASE_ADDR[23:8]);

	// ------------------------------------------------------------
	// Handshake
	// ------------------------------------------------------------
	// Writes are never stretched
	write_no_wait: assert property (@(posedge clk) disable iff (rst) (vda && !rw) |-> rdy)
		else begin
			$error("rdy low during a bus write");
			fail_cnt++;
		end

	// Exactly two wait states per read
	read_two_waits: assert property (@(posedge clk) disable iff (rst)
		$fell(rdy) |=> !rdy ##1 rdy)
		else begin
			$error("rdy did not rise two cycles after it fell");
			fail_cnt++;
		end

	// Data cycle of a read
	read_data_known: assert property (@(posedge clk) disable iff (rst)
		(rd_sel && rdy) |-> !$isunknown(rdata))
		else begin
			$error("rdata unknown in the read data cycle");
			fail_cnt++;
		end

	// Idle bus once reset is released
	rdy_after_reset: assert property (@(posedge clk) $fell(rst) |-> rdy)
		else begin
			$error("rdy low right after reset");
			fail_cnt++;
		end

endmodule

`default_nettype wire

// ==== tests/fxp_accel_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module fxp_accel_tb;

	localparam int          FAC_BYTES   = 10;
	localparam int          W           = 8 * FAC_BYTES;
	localparam logic [15:0] BASE_HIGH   = 16'hFEA2;
	localparam int          RDY_TIMEOUT = 8;
	localparam int          RST_TIMEOUT = 16;
	localparam int          IDLE_POLLS  = 128;
	localparam logic [W-1:0] FAC_MIN    = {1'b1, {(W-1){1'b0}}};
	localparam logic [W-1:0] FAC_MAX    = ~FAC_MIN;

	logic        clk;
	logic        rst;
	logic        vda;
	logic        rw;
	logic [23:0] ad;
	logic [7:0]  wdata;
	logic [7:0]  rdata;
	logic        rdy;

	int unsigned  checks = 0;
	int unsigned  errors = 0;
	logic         model_vf = 1'b0;
	logic [W-1:0] edge_vals [5];

	tb_clock u_clock (.clk(clk), .rst(rst));

	fxp_accel u_dut (
		.clk(clk), .rst(rst), .vda(vda), .rw(rw), .ad(ad),
		.wdata(wdata), .rdata(rdata), .rdy(rdy)
	);

	bind fxp_accel fxp_accel_checker #(.BASE_ADDR(BASE_ADDR)) u_checker (
		.clk(clk), .rst(rst), .vda(vda), .rw(rw), .ad(ad), .rdata(rdata), .rdy(rdy)
	);

	task automatic print_counts();
		$display("Summary: %0d checks, %0d value errors, %0d protocol assertion failures",
			checks, errors, u_dut.u_checker.fail_cnt);
	endtask

	task automatic abort_run(input string what);
		$display("Timeout: %s", what);
		print_counts();
		$display("FAIL: see errors above");
		$finish;
	endtask

	task automatic check_hex(input string name, input logic [W-1:0] got,
			input logic [W-1:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("ERROR %s: got %0h expected %0h", name, got, exp);
			errors++;
		end
	endtask

	// ------------------------------------------------------------
	// Bus master
	// ------------------------------------------------------------
	// Each access starts 1 ns after an edge and returns 1 ns after its last edge
	task automatic bus_write(input logic [7:0] offset, input logic [7:0] data);
		int cycles;
		cycles = 0;
		vda = 1'b1;
		rw = 1'b0;
		ad = {BASE_HIGH, offset};
		wdata = data;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > RDY_TIMEOUT) abort_run("rdy never rose during a write");
		end while (!rdy);
		@(posedge clk);
		#1;
		vda = 1'b0;
	endtask

	task automatic bus_read(input logic [7:0] offset, output logic [7:0] data);
		int cycles;
		cycles = 0;
		vda = 1'b1;
		rw = 1'b1;
		ad = {BASE_HIGH, offset};
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > RDY_TIMEOUT) abort_run("rdy never rose during a read");
		end while (!rdy);
		// Registered byte is stable for the whole data cycle
		data = rdata;
		@(posedge clk);
		#1;
		vda = 1'b0;
		rw = 1'b0;
	endtask

	task automatic load_fac(input logic [7:0] base, input logic [W-1:0] value);
		for (int i = 0; i < FAC_BYTES; i++)
			bus_write(base + 8'(i), value[8*i +: 8]);
	endtask

	task automatic read_fac(input logic [7:0] base, output logic [W-1:0] value);
		logic [7:0] b;
		for (int i = 0; i < FAC_BYTES; i++) begin
			bus_read(base + 8'(i), b);
			value[8*i +: 8] = b;
		end
	endtask

	task automatic wait_reset();
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > RST_TIMEOUT) abort_run("reset was never released");
		end while (rst);
		@(posedge clk);
		#1;
	endtask

	// Polls the status byte until busy clears
	task automatic wait_idle(output logic [7:0] st);
		int polls;
		polls = 0;
		do begin
			bus_read(fxp_bus_pkg::CMD_OFFSET, st);
			polls++;
			if (polls > IDLE_POLLS) abort_run("busy never cleared");
		end while (st[7]);
	endtask

	// ------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------
	function automatic logic [W-1:0] rand_fac();
		logic [95:0] r;
		r = {$urandom(), $urandom(), $urandom()};
		return r[W-1:0];
	endfunction

	// Idle status from the compare of FAC1 against FAC2
	function automatic logic [7:0] expected_status(input logic [W-1:0] f1,
			input logic [W-1:0] f2, input logic v);
		logic gt;
		logic eq;
		gt = $signed(f1) > $signed(f2);
		eq = f1 == f2;
		return {1'b0, 2'b00, !(gt || eq), eq, gt, f1 == {W{1'b0}}, v};
	endfunction

	task automatic check_op(input logic [7:0] op, input logic [W-1:0] a,
			input logic [W-1:0] b);
		logic [W-1:0]      exp1;
		logic [W-1:0]      exp2;
		logic [W-1:0]      ma;
		logic [W-1:0]      mb;
		logic [2*W-1:0]    prod;
		logic signed [W:0] wide;
		logic [W-1:0]      got;
		logic [7:0]        st;
		exp1 = a;
		exp2 = b;
		ma = a[W-1] ? -a : a;
		mb = b[W-1] ? -b : b;
		case (op)
			fxp_op_pkg::OP_ADD, fxp_op_pkg::OP_SUB: begin
				if (op == fxp_op_pkg::OP_ADD)
					wide = $signed({b[W-1], b}) + $signed({a[W-1], a});
				else
					wide = $signed({b[W-1], b}) - $signed({a[W-1], a});
				exp1 = wide[W-1:0];
				// Result does not fit in W signed bits
				model_vf = wide[W] ^ wide[W-1];
			end
			fxp_op_pkg::OP_NEG: begin
				exp1 = -a;
				model_vf = a == FAC_MIN;
			end
			fxp_op_pkg::OP_ABS: begin
				exp1 = ma;
				model_vf = a == FAC_MIN;
			end
			fxp_op_pkg::OP_NABS: begin
				exp1 = a[W-1] ? a : -a;
				model_vf = 1'b0;
			end
			fxp_op_pkg::OP_SWAP: begin
				exp1 = b;
				exp2 = a;
			end
			default: begin
				// Upper half of the magnitude product with the multiplicand left in FAC2
				prod = {{W{1'b0}}, ma} * {{W{1'b0}}, mb};
				exp1 = (a[W-1] ^ b[W-1]) ? -prod[2*W-1:W] : prod[2*W-1:W];
				exp2 = ma;
				model_vf = 1'b0;
			end
		endcase
		load_fac(fxp_bus_pkg::FAC1_BASE, a);
		load_fac(fxp_bus_pkg::FAC2_BASE, b);
		bus_write(fxp_bus_pkg::CMD_OFFSET, op);
		if (op == fxp_op_pkg::OP_MUL) begin
			// Lands while the multiply runs and must be dropped
			bus_write(fxp_bus_pkg::FAC2_BASE, ~b[7:0]);
			wait_idle(st);
		end else begin
			// Single step results are done by the time this read samples
			bus_read(fxp_bus_pkg::CMD_OFFSET, st);
		end
		check_hex($sformatf("status after op %h", op), W'(st),
			W'(expected_status(exp1, exp2, model_vf)));
		read_fac(fxp_bus_pkg::FAC1_BASE, got);
		check_hex($sformatf("fac1 after op %h", op), got, exp1);
		read_fac(fxp_bus_pkg::FAC2_BASE, got);
		check_hex($sformatf("fac2 after op %h", op), got, exp2);
	endtask

	// ------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------
	initial begin
		logic [W-1:0] a;
		logic [W-1:0] b;
		vda = 1'b0;
		rw = 1'b0;
		ad = 24'h000000;
		wdata = 8'h00;
		void'($urandom(28779));
		edge_vals = '{{W{1'b0}}, W'(1), FAC_MAX, FAC_MIN, {W{1'b1}}};
		wait_reset();

		// Edge operands cover carry, overflow, zero and equality
		foreach (edge_vals[i]) begin
			foreach (edge_vals[j]) begin
				check_op(fxp_op_pkg::OP_ADD, edge_vals[i], edge_vals[j]);
				check_op(fxp_op_pkg::OP_SUB, edge_vals[i], edge_vals[j]);
				check_op(fxp_op_pkg::OP_SWAP, edge_vals[i], edge_vals[j]);
				check_op(fxp_op_pkg::OP_MUL, edge_vals[i], edge_vals[j]);
			end
			check_op(fxp_op_pkg::OP_NEG, edge_vals[i], rand_fac());
			check_op(fxp_op_pkg::OP_ABS, edge_vals[i], rand_fac());
			check_op(fxp_op_pkg::OP_NABS, edge_vals[i], rand_fac());
		end

		repeat (8) begin
			a = rand_fac();
			b = rand_fac();
			check_op(fxp_op_pkg::OP_ADD, a, b);
			check_op(fxp_op_pkg::OP_SUB, a, b);
			check_op(fxp_op_pkg::OP_NEG, a, b);
			check_op(fxp_op_pkg::OP_ABS, a, b);
			check_op(fxp_op_pkg::OP_NABS, a, b);
			check_op(fxp_op_pkg::OP_SWAP, a, b);
			check_op(fxp_op_pkg::OP_MUL, a, b);
		end

		print_counts();
		if (errors == 0 && u_dut.u_checker.fail_cnt == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
rtl/fxp_bus_pkg.sv
rtl/fxp_op_pkg.sv
rtl/fxp_bus_port.sv
rtl/fxp_regs.sv
rtl/fxp_alu.sv
rtl/fxp_sequencer.sv
rtl/fxp_accel.sv
tests/tb_clock.sv
tests/fxp_accel_checker.sv
tests/fxp_accel_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal
TOP       ?= fxp_accel_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := PASS: all tests

.PHONY: sim clean

# Assertion failures are counted by the testbench, so the run is not stopped early
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
